//--- logic/img_params.svh
`ifndef IMG_PARAMS_SVH
`define IMG_PARAMS_SVH

// Map geometry
`define MAP_COL        8
`define MAP_ROW        8

// Channel depth limits
`define MAP_DEPTH_MAX  32
`define MAP_DEPTH_MIN  8

// Whole image, also the load length
`define MAP_PIXELS     2048

// Channels covered by the median filter
`define MED_CHANNELS   4

`define OUT_W          14

`endif

//--- logic/img_pkg.sv
`default_nettype none

`include "img_params.svh"

package img_pkg;

	typedef logic [7:0] pixel_t;

	// x or y position on the map
	typedef logic [$clog2(`MAP_COL)-1:0] coord_t;

	// Holds 8, 16 or 32
	typedef logic [$clog2(`MAP_DEPTH_MAX):0] depth_t;

	// channel * 64 + y * 8 + x
	typedef logic [$clog2(`MAP_PIXELS)-1:0] addr_t;

	typedef logic [`OUT_W-1:0] out_word_t;

endpackage

`default_nettype wire

//--- logic/op_pkg.sv
`default_nettype none

package op_pkg;

	typedef enum logic [3:0] {
		OP_LOAD     = 4'd0,
		OP_RIGHT    = 4'd1,
		OP_LEFT     = 4'd2,
		OP_UP       = 4'd3,
		OP_DOWN     = 4'd4,
		OP_SCALE_DN = 4'd5,
		OP_SCALE_UP = 4'd6,
		OP_DISPLAY  = 4'd7,
		OP_CONV     = 4'd8,
		OP_MEDIAN   = 4'd9,
		OP_SOBEL    = 4'd10
	} op_mode_t;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_LOAD,
		ST_DISPLAY,
		ST_MEDIAN,
		ST_DONE
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/op_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "img_params.svh"

module op_ctrl
	import img_pkg::*;
	import op_pkg::*;
(
	input  wire            i_clk,
	input  wire            i_rst_n,
	input  wire            i_op_valid,
	input  wire op_mode_t  i_op_mode,
	input  wire            i_done,
	output logic           o_op_ready,
	output logic           o_in_ready,
	output logic           o_load_start,
	output logic           o_disp_start,
	output logic           o_med_start,
	output coord_t         o_org_x,
	output coord_t         o_org_y,
	output depth_t         o_depth
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	op_mode_t    op_q;

	assign o_op_ready   = (state == ST_FETCH);
	assign o_load_start = (state == ST_DECODE) && (op_q == OP_LOAD);
	assign o_disp_start = (state == ST_DECODE) && (op_q == OP_DISPLAY);
	assign o_med_start  = (state == ST_DECODE) && (op_q == OP_MEDIAN);

	// ------------------------------------------------------------------
	// Operation FSM
	// ------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			ST_FETCH: begin
				if (i_op_valid)
					state_nxt = ST_DECODE;
			end
			ST_DECODE: begin
				case (op_q)
					OP_LOAD:    state_nxt = ST_LOAD;
					OP_DISPLAY: state_nxt = ST_DISPLAY;
					OP_MEDIAN:  state_nxt = ST_MEDIAN;
					// Not implemented, accepted as no-op
					OP_CONV, OP_SOBEL: state_nxt = ST_FETCH;
					default:    state_nxt = ST_FETCH;
				endcase
			end
			ST_LOAD, ST_DISPLAY, ST_MEDIAN: begin
				if (i_done)
					state_nxt = ST_DONE;
			end
			default: state_nxt = ST_FETCH;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= ST_FETCH;
			op_q       <= OP_LOAD;
			o_in_ready <= 1'b0;
		end else begin
			state <= state_nxt;
			if (o_op_ready && i_op_valid)
				op_q <= i_op_mode;
			if (o_load_start)
				o_in_ready <= 1'b1;
			else if ((state == ST_LOAD) && i_done)
				o_in_ready <= 1'b0;
		end
	end

	// Shift and scale, applied in decode
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_org_x <= '0;
			o_org_y <= '0;
			o_depth <= depth_t'(`MAP_DEPTH_MAX);
		end else if (state == ST_DECODE) begin
			case (op_q)
				OP_RIGHT:    if (o_org_x < coord_t'(`MAP_COL - 2)) o_org_x <= o_org_x + 3'd1;
				OP_LEFT:     if (o_org_x != '0) o_org_x <= o_org_x - 3'd1;
				OP_UP:       if (o_org_y != '0) o_org_y <= o_org_y - 3'd1;
				OP_DOWN:     if (o_org_y < coord_t'(`MAP_ROW - 2)) o_org_y <= o_org_y + 3'd1;
				OP_SCALE_DN: if (o_depth > depth_t'(`MAP_DEPTH_MIN)) o_depth <= o_depth >> 1;
				OP_SCALE_UP: if (o_depth < depth_t'(`MAP_DEPTH_MAX)) o_depth <= o_depth << 1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "img_params.svh"

module addr_gen
	import img_pkg::*;
(
	input  wire          i_clk,
	input  wire          i_rst_n,
	input  wire          i_load_start,
	input  wire          i_disp_start,
	input  wire          i_med_start,
	input  wire          i_in_valid,
	input  wire coord_t  i_org_x,
	input  wire coord_t  i_org_y,
	input  wire depth_t  i_depth,
	input  wire          i_drained,
	output addr_t        o_addr,
	output logic         o_cen,
	output logic         o_wen,
	output logic         o_rd_valid,
	output logic         o_pad,
	output logic [3:0]   o_slot,
	output logic         o_done
);

	localparam addr_t med_end = addr_t'(`MED_CHANNELS * 16);

	logic       load_q;
	logic       disp_q;
	logic       med_q;
	logic       walk_q;
	logic       done_q;
	addr_t      step;
	coord_t     dx;
	coord_t     dy;
	coord_t     mx;
	coord_t     my;
	logic [3:0] sx;
	logic [3:0] sy;
	logic       on_map;
	logic       load_last;
	logic       disp_last;
	logic       rd_now;
	logic       pad_now;
	logic [3:0] slot_now;

	assign load_last = (step == addr_t'(`MAP_PIXELS - 1));
	assign disp_last = (step == addr_t'({i_depth, 2'b00} - 8'd1));

	// Display quad: bit 0 steps x, bit 1 steps y, upper bits pick the channel
	assign dx = i_org_x + {2'b00, step[0]};
	assign dy = i_org_y + {2'b00, step[1]};

	// Median window starts one up and one left of the origin
	assign sx     = {1'b0, i_org_x} + {2'b00, step[1:0]};
	assign sy     = {1'b0, i_org_y} + {2'b00, step[3:2]};
	assign mx     = sx[2:0] - 3'd1;
	assign my     = sy[2:0] - 3'd1;
	assign on_map = (sx != 4'd0) && (sx <= 4'(`MAP_COL)) && (sy != 4'd0) && (sy <= 4'(`MAP_ROW));

	always_comb begin
		o_addr = '0;
		o_cen  = 1'b1;
		o_wen  = 1'b1;
		if (load_q) begin
			o_addr = step;
			o_cen  = !i_in_valid;
			o_wen  = 1'b0;
		end else if (disp_q) begin
			o_addr = {step[6:2], dy, dx};
			o_cen  = 1'b0;
		end else if (walk_q) begin
			o_addr = {3'b000, step[5:4], my, mx};
			o_cen  = !on_map;
		end
	end

	assign rd_now   = disp_q || (walk_q && on_map);
	assign pad_now  = walk_q && !on_map;
	assign slot_now = walk_q ? step[3:0] : 4'h0;

	assign o_done = (load_q && i_in_valid && load_last) || done_q;

	// ------------------------------------------------------------------
	// Step counter and read tag, tag lines up with RAM output
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			load_q     <= 1'b0;
			disp_q     <= 1'b0;
			med_q      <= 1'b0;
			walk_q     <= 1'b0;
			done_q     <= 1'b0;
			step       <= '0;
			o_rd_valid <= 1'b0;
			o_pad      <= 1'b0;
			o_slot     <= '0;
		end else begin
			done_q     <= 1'b0;
			o_rd_valid <= rd_now;
			o_pad      <= pad_now;
			o_slot     <= slot_now;
			if (i_load_start) begin
				load_q <= 1'b1;
				step   <= '0;
			end else if (i_disp_start) begin
				disp_q <= 1'b1;
				step   <= '0;
			end else if (i_med_start) begin
				med_q  <= 1'b1;
				walk_q <= 1'b1;
				step   <= '0;
			end else if (load_q) begin
				if (i_in_valid) begin
					step <= step + 1'b1;
					if (load_last)
						load_q <= 1'b0;
				end
			end else if (disp_q) begin
				step <= step + 1'b1;
				if (disp_last) begin
					disp_q <= 1'b0;
					done_q <= 1'b1;
				end
			end else if (walk_q) begin
				step <= step + 1'b1;
				// Hold after slot 15 until out_stage has drained the window
				if (step[3:0] == 4'hf)
					walk_q <= 1'b0;
			end else if (med_q && i_drained) begin
				if (step == med_end) begin
					med_q  <= 1'b0;
					done_q <= 1'b1;
				end else begin
					walk_q <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/image_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "img_params.svh"

module image_ram
	import img_pkg::*;
(
	input  wire          i_clk,
	input  wire          i_cen,
	input  wire          i_wen,
	input  wire addr_t   i_addr,
	input  wire pixel_t  i_data,
	output pixel_t       o_q
);

	pixel_t mem [`MAP_PIXELS];

	// Enables active low, read data one cycle later
	always_ff @(posedge i_clk) begin
		if (!i_cen) begin
			if (!i_wen)
				mem[i_addr] <= i_data;
			else
				o_q <= mem[i_addr];
		end
	end

endmodule

`default_nettype wire

//--- logic/window_buf.sv
`timescale 1ns/1ps
`default_nettype none

module window_buf
	import img_pkg::*;
(
	input  wire          i_clk,
	input  wire          i_rst_n,
	input  wire          i_rd_valid,
	input  wire          i_pad,
	input  wire [3:0]    i_slot,
	input  wire pixel_t  i_q,
	output pixel_t [15:0] o_win,
	output logic         o_full
);

	logic wr;

	// Either a real read or an off-map position fills the slot
	assign wr = i_rd_valid || i_pad;

	always_ff @(posedge i_clk) begin
		if (wr) begin
			if (i_pad)
				o_win[i_slot] <= '0;
			else
				o_win[i_slot] <= i_q;
		end
	end

	// Window complete one cycle after the last slot lands
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_full <= 1'b0;
		else
			o_full <= wr && (i_slot == 4'hf);
	end

endmodule

`default_nettype wire

//--- logic/median3x3.sv
`timescale 1ns/1ps
`default_nettype none

module median3x3
	import img_pkg::*;
(
	input  wire pixel_t [8:0] i_pix,
	output pixel_t            o_med
);

	// 19 compare-exchange steps, smaller value lands on lo_idx
	localparam int n_cmp = 19;
	localparam int lo_idx [n_cmp] = '{1, 4, 7, 0, 3, 6, 1, 4, 7, 0, 5, 4, 3, 1, 2, 4, 4, 6, 4};
	localparam int hi_idx [n_cmp] = '{2, 5, 8, 1, 4, 7, 2, 5, 8, 3, 8, 7, 6, 4, 5, 7, 2, 4, 2};

	pixel_t v [9];
	pixel_t a;
	pixel_t b;

	always_comb begin
		for (int i = 0; i < 9; i++) begin
			v[i] = i_pix[i];
		end
		for (int k = 0; k < n_cmp; k++) begin
			a = v[lo_idx[k]];
			b = v[hi_idx[k]];
			v[lo_idx[k]] = (a < b) ? a : b;
			v[hi_idx[k]] = (a < b) ? b : a;
		end
	end

	// Fifth smallest ends up in the middle
	assign o_med = v[4];

endmodule

`default_nettype wire

//--- logic/out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module out_stage
	import img_pkg::*;
(
	input  wire               i_clk,
	input  wire               i_rst_n,
	input  wire               i_rd_valid,
	input  wire               i_disp,
	input  wire pixel_t       i_q,
	input  wire               i_full,
	input  wire pixel_t [3:0] i_med,
	output logic              o_out_valid,
	output out_word_t         o_out_data,
	output logic              o_drained
);

	logic         disp_q;
	logic         rd_q;
	logic         busy;
	logic [1:0]   cnt;
	pixel_t [3:0] med_q;

	// Display stream is contiguous, so it ends where the read tags stop
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			disp_q <= 1'b0;
			rd_q   <= 1'b0;
		end else begin
			rd_q <= i_rd_valid;
			if (i_disp)
				disp_q <= 1'b1;
			else if (rd_q && !i_rd_valid)
				disp_q <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_full)
			med_q <= i_med;
	end

	// ------------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy        <= 1'b0;
			cnt         <= '0;
			o_out_valid <= 1'b0;
			o_out_data  <= '0;
			o_drained   <= 1'b0;
		end else begin
			o_out_valid <= (disp_q && i_rd_valid) || i_full || busy;
			o_drained   <= busy && (cnt == 2'd3);
			if (i_full) begin
				busy <= 1'b1;
				cnt  <= 2'd1;
			end else if (busy) begin
				cnt <= cnt + 2'd1;
				if (cnt == 2'd3)
					busy <= 1'b0;
			end
			if (disp_q && i_rd_valid)
				o_out_data <= out_word_t'(i_q);
			else if (i_full)
				o_out_data <= out_word_t'(i_med[0]);
			else if (busy)
				o_out_data <= out_word_t'(med_q[cnt]);
		end
	end

endmodule

`default_nettype wire

//--- logic/image_core.sv
`timescale 1ns/1ps
`default_nettype none

module image_core
	import img_pkg::*;
	import op_pkg::*;
(
	input  wire            i_clk,
	input  wire            i_rst_n,
	input  wire            i_op_valid,
	input  wire op_mode_t  i_op_mode,
	output logic           o_op_ready,
	input  wire            i_in_valid,
	input  wire pixel_t    i_in_data,
	output logic           o_in_ready,
	output logic           o_out_valid,
	output out_word_t      o_out_data
);

	wire               load_start;
	wire               disp_start;
	wire               med_start;
	wire               done;
	wire coord_t       org_x;
	wire coord_t       org_y;
	wire depth_t       depth;
	wire addr_t        addr;
	wire               cen;
	wire               wen;
	wire               rd_valid;
	wire               pad;
	wire [3:0]         slot;
	wire               drained;
	wire pixel_t       q;
	wire pixel_t [15:0] win;
	wire               full;
	wire pixel_t [3:0] med;

	op_ctrl u_op_ctrl (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_op_valid   (i_op_valid),
		.i_op_mode    (i_op_mode),
		.i_done       (done),
		.o_op_ready   (o_op_ready),
		.o_in_ready   (o_in_ready),
		.o_load_start (load_start),
		.o_disp_start (disp_start),
		.o_med_start  (med_start),
		.o_org_x      (org_x),
		.o_org_y      (org_y),
		.o_depth      (depth)
	);

	addr_gen u_addr_gen (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_load_start (load_start),
		.i_disp_start (disp_start),
		.i_med_start  (med_start),
		.i_in_valid   (i_in_valid),
		.i_org_x      (org_x),
		.i_org_y      (org_y),
		.i_depth      (depth),
		.i_drained    (drained),
		.o_addr       (addr),
		.o_cen        (cen),
		.o_wen        (wen),
		.o_rd_valid   (rd_valid),
		.o_pad        (pad),
		.o_slot       (slot),
		.o_done       (done)
	);

	image_ram u_image_ram (
		.i_clk  (i_clk),
		.i_cen  (cen),
		.i_wen  (wen),
		.i_addr (addr),
		.i_data (i_in_data),
		.o_q    (q)
	);

	window_buf u_window_buf (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_rd_valid (rd_valid),
		.i_pad      (pad),
		.i_slot     (slot),
		.i_q        (q),
		.o_win      (win),
		.o_full     (full)
	);

	// Four 3x3 neighborhoods inside the 4x4 window, k = 0 is the origin
	for (genvar k = 0; k < 4; k++) begin : g_med
		localparam int base = (k / 2) * 4 + (k % 2);

		median3x3 u_median3x3 (
			.i_pix ({win[base+10], win[base+9], win[base+8],
			         win[base+6], win[base+5], win[base+4],
			         win[base+2], win[base+1], win[base]}),
			.o_med (med[k])
		);
	end

	out_stage u_out_stage (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_rd_valid  (rd_valid),
		.i_disp      (disp_start),
		.i_q         (q),
		.i_full      (full),
		.i_med       (med),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_drained   (drained)
	);

endmodule

`default_nettype wire

//--- dv/tb_image_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "img_params.svh"

module tb_image_core
	import img_pkg::*;
	import op_pkg::*;
();

	localparam int n_moves     = 100;
	localparam int n_displays  = 12;
	localparam int load_cycles = 2 * `MAP_PIXELS;
	localparam int disp_cycles = 4 * `MAP_DEPTH_MAX + 8;
	localparam int med_cycles  = `MED_CHANNELS * 40 + 8;
	localparam int limit_cycles = 2 * (8 + load_cycles + n_displays * disp_cycles
		+ 2 * med_cycles + 4 * n_moves);

	logic      i_clk;
	logic      i_rst_n;
	logic      i_op_valid;
	op_mode_t  i_op_mode;
	logic      o_op_ready;
	logic      i_in_valid;
	pixel_t    i_in_data;
	logic      o_in_ready;
	logic      o_out_valid;
	out_word_t o_out_data;

	integer    seed = 32'h7978_41f2;

	// Reference image model
	pixel_t    ref_img [`MAP_PIXELS];
	int        ref_x;
	int        ref_y;
	int        ref_depth;

	out_word_t exp_q [$];
	int        words_seen;
	string     cur_test;

	image_core i_dut (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.o_op_ready  (o_op_ready),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// ------------------------------------------------------------------
	// Error reporting and compare tasks
	// ------------------------------------------------------------------
	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_word(input string name, input out_word_t exp, input out_word_t act);
		if (act !== exp)
			report_error($sformatf("CHECK FAILED %s: expected 0x%04h, actual 0x%04h",
				name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			report_error($sformatf("CHECK FAILED %s: expected %0d words, actual %0d words",
				name, exp, act));
	endtask

	task automatic verify_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_error($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------
	function automatic pixel_t pixel_at(input int c, input int x, input int y);
		if (x < 0 || x >= `MAP_COL || y < 0 || y >= `MAP_ROW)
			return '0;
		return ref_img[c * `MAP_COL * `MAP_ROW + y * `MAP_COL + x];
	endfunction

	// Median of the 3x3 neighborhood with zero outside the map
	function automatic pixel_t median_at(input int c, input int cx, input int cy);
		pixel_t v [9];
		pixel_t t;
		int     j;
		for (int i = 0; i < 9; i++) begin
			v[i] = pixel_at(c, cx - 1 + i % 3, cy - 1 + i / 3);
		end
		for (int i = 1; i < 9; i++) begin
			t = v[i];
			j = i - 1;
			while (j >= 0 && v[j] > t) begin
				v[j + 1] = v[j];
				j--;
			end
			v[j + 1] = t;
		end
		return v[4];
	endfunction

	function automatic void apply_to_model(input op_mode_t op);
		case (op)
			OP_RIGHT:    if (ref_x < `MAP_COL - 2) ref_x++;
			OP_LEFT:     if (ref_x > 0) ref_x--;
			OP_UP:       if (ref_y > 0) ref_y--;
			OP_DOWN:     if (ref_y < `MAP_ROW - 2) ref_y++;
			OP_SCALE_DN: if (ref_depth > `MAP_DEPTH_MIN) ref_depth = ref_depth / 2;
			OP_SCALE_UP: if (ref_depth < `MAP_DEPTH_MAX) ref_depth = ref_depth * 2;
			default: ;
		endcase
	endfunction

	function automatic void display_words();
		for (int c = 0; c < ref_depth; c++) begin
			exp_q.push_back(out_word_t'(pixel_at(c, ref_x, ref_y)));
			exp_q.push_back(out_word_t'(pixel_at(c, ref_x + 1, ref_y)));
			exp_q.push_back(out_word_t'(pixel_at(c, ref_x, ref_y + 1)));
			exp_q.push_back(out_word_t'(pixel_at(c, ref_x + 1, ref_y + 1)));
		end
	endfunction

	function automatic void median_words();
		for (int c = 0; c < `MED_CHANNELS; c++) begin
			exp_q.push_back(out_word_t'(median_at(c, ref_x, ref_y)));
			exp_q.push_back(out_word_t'(median_at(c, ref_x + 1, ref_y)));
			exp_q.push_back(out_word_t'(median_at(c, ref_x, ref_y + 1)));
			exp_q.push_back(out_word_t'(median_at(c, ref_x + 1, ref_y + 1)));
		end
	endfunction

	// ------------------------------------------------------------------
	// Stimulus tasks
	// ------------------------------------------------------------------
	task automatic wait_op_ready();
		while (!o_op_ready) begin
			@(posedge i_clk);
			#1;
		end
	endtask

	task automatic issue_op(input op_mode_t op);
		wait_op_ready();
		i_op_valid = 1'b1;
		i_op_mode  = op;
		@(posedge i_clk);
		#1;
		i_op_valid = 1'b0;
	endtask

	task automatic run_move(input string name, input op_mode_t op, input int times);
		cur_test   = name;
		words_seen = 0;
		repeat (times) begin
			issue_op(op);
			apply_to_model(op);
			wait_op_ready();
		end
		check_count(name, 0, words_seen);
	endtask

	task automatic run_display(input string name);
		cur_test   = name;
		words_seen = 0;
		display_words();
		issue_op(OP_DISPLAY);
		wait_op_ready();
		check_count(name, 4 * ref_depth, words_seen);
	endtask

	task automatic run_median(input string name);
		cur_test   = name;
		words_seen = 0;
		median_words();
		issue_op(OP_MEDIAN);
		wait_op_ready();
		check_count(name, 4 * `MED_CHANNELS, words_seen);
	endtask

	// Source drops valid now and then and puts junk on the data bus
	task automatic load_image();
		pixel_t pix;
		cur_test = "load";
		issue_op(OP_LOAD);
		while (!o_in_ready) begin
			@(posedge i_clk);
			#1;
		end
		for (int n = 0; n < `MAP_PIXELS; n++) begin
			if (($random(seed) & 7) == 0) begin
				i_in_valid = 1'b0;
				i_in_data  = pixel_t'($random(seed));
				@(posedge i_clk);
				#1;
			end
			pix        = pixel_t'($random(seed));
			ref_img[n] = pix;
			i_in_valid = 1'b1;
			i_in_data  = pix;
			@(posedge i_clk);
			#1;
		end
		i_in_valid = 1'b0;
		verify_flag("load in_ready falls", 1'b0, o_in_ready);
		wait_op_ready();
	endtask

	// ------------------------------------------------------------------
	// Compare process
	// ------------------------------------------------------------------
	initial begin
		out_word_t exp;
		forever begin
			@(negedge i_clk);
			if (i_rst_n === 1'b1 && o_out_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					report_error($sformatf("Output word 0x%04h appeared in %s with none expected",
						o_out_data, cur_test));
				end else begin
					exp = exp_q.pop_front();
					check_word(cur_test, exp, o_out_data);
					words_seen++;
				end
			end
		end
	end

	// Watchdog
	initial begin
		repeat (limit_cycles) @(posedge i_clk);
		report_error("Watchdog expired because the run did not finish in time");
	end

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin
		i_rst_n    = 1'b0;
		i_op_valid = 1'b0;
		i_op_mode  = OP_LOAD;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		words_seen = 0;
		cur_test   = "reset";
		ref_x      = 0;
		ref_y      = 0;
		ref_depth  = `MAP_DEPTH_MAX;
		repeat (8) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		@(posedge i_clk);
		#1;
		verify_flag("reset op_ready", 1'b1, o_op_ready);
		verify_flag("reset in_ready", 1'b0, o_in_ready);
		verify_flag("reset out_valid", 1'b0, o_out_valid);

		load_image();
		run_display("display at reset origin");

		// Shifts with clamping at the edges
		run_move("shift right past edge", OP_RIGHT, 9);
		run_display("display after right");
		run_move("shift down past edge", OP_DOWN, 9);
		run_display("display after down");
		run_move("shift left", OP_LEFT, 3);
		run_display("display after left");
		run_move("shift up", OP_UP, 2);
		run_display("display after up");
		run_move("shift left past edge", OP_LEFT, 6);
		run_display("display after left clamp");
		run_move("shift up past edge", OP_UP, 7);
		run_display("display after up clamp");

		// Scale tests away from the corner
		run_move("move for scale", OP_RIGHT, 2);
		run_move("move for scale", OP_DOWN, 3);
		run_move("scale down 16", OP_SCALE_DN, 1);
		run_display("display depth 16");
		run_move("scale down 8", OP_SCALE_DN, 1);
		run_display("display depth 8");
		run_move("scale down clamped", OP_SCALE_DN, 1);
		run_display("display depth 8 clamped");
		run_move("scale up 16", OP_SCALE_UP, 1);
		run_display("display depth 16 again");

		// Median at both corners with zero padding outside
		run_move("move to top left", OP_LEFT, 7);
		run_move("move to top left", OP_UP, 7);
		run_median("median at 0,0");
		run_move("move to bottom right", OP_RIGHT, 7);
		run_move("move to bottom right", OP_DOWN, 7);
		run_median("median at 6,6");

		run_move("convolution no-op", OP_CONV, 1);
		run_move("sobel no-op", OP_SOBEL, 1);

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/img_pkg.sv
logic/op_pkg.sv
logic/op_ctrl.sv
logic/addr_gen.sv
logic/image_ram.sv
logic/window_buf.sv
logic/median3x3.sv
logic/out_stage.sv
logic/image_core.sv
dv/tb_image_core.sv
